//--- Makefile
# Verilator build and run for the pipeline back end

VERILATOR ?= verilator
TOP       ?= be_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F -e '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- flist.f
src/be_pkg.sv
src/gpr_file.sv
src/csr_file.sv
src/data_ram.sv
src/mem_stage.sv
src/wb_stage.sv
src/be_top.sv
tests/be_tb.sv

//--- src/be_pkg.sv
// back-end package: widths, memory and CSR encodings, stage payload structs

package be_pkg;

  localparam int XLEN        = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int CSR_ADDR_WD = 12;

  typedef enum logic [1:0] {
    MEM_NONE = 2'd0,
    MEM_LW   = 2'd1,
    MEM_SW   = 2'd2
  } mem_op_e;

  // standard machine-mode addresses
  typedef enum logic [CSR_ADDR_WD-1:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MTVEC   = 12'h305,
    CSR_MEPC    = 12'h341,
    CSR_MCAUSE  = 12'h342
  } csr_addr_e;

  typedef struct packed {
    logic [XLEN-1:0]        pc;
    logic [XLEN-1:0]        inst;
    mem_op_e                mem_op;
    // also the load/store address
    logic [XLEN-1:0]        alu_result;
    logic [XLEN-1:0]        store_data;
    logic                   gpr_wen;
    logic [GPR_ADDR_WD-1:0] rd;
    logic                   csr_wen;
    logic [CSR_ADDR_WD-1:0] csr;
    logic [XLEN-1:0]        csr_wdata;
  } ex_to_ms_t;

  typedef struct packed {
    logic [XLEN-1:0]        pc;
    logic [XLEN-1:0]        inst;
    logic                   gpr_wen;
    logic [GPR_ADDR_WD-1:0] rd;
    logic [XLEN-1:0]        gpr_result;
    logic                   csr_wen;
    logic [CSR_ADDR_WD-1:0] csr;
    logic [XLEN-1:0]        csr_result;
  } ms_to_ws_t;

  typedef struct packed {
    logic                   gpr_wen;
    logic [GPR_ADDR_WD-1:0] gpr_waddr;
    logic [XLEN-1:0]        gpr_wdata;
    logic                   csr_wen;
    logic [CSR_ADDR_WD-1:0] csr_waddr;
    logic [XLEN-1:0]        csr_wdata;
  } ws_to_rf_t;

  typedef struct packed {
    logic                   valid;
    logic [XLEN-1:0]        pc;
    logic [XLEN-1:0]        inst;
    logic                   gpr_wen;
    logic [GPR_ADDR_WD-1:0] rd;
    logic [XLEN-1:0]        gpr_data;
  } commit_t;

  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic            we;
    logic [XLEN-1:0] adr;
    logic [XLEN-1:0] dat_w;
  } wb_req_t;

endpackage

//--- src/be_top.sv
// pipeline back end: memory and write-back stages, register files, data RAM

module be_top #(
  parameter int RAM_AW = 8
) (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  // execute side
  input  logic                           i_ex_valid,
  input  be_pkg::ex_to_ms_t              i_ex_bus,
  output logic                           o_ms_allowin,
  // debug and hazard
  output be_pkg::commit_t                o_commit,
  output logic [be_pkg::GPR_ADDR_WD-1:0] o_ms_gpr_rd,
  output logic [be_pkg::GPR_ADDR_WD-1:0] o_ws_gpr_rd,
  output logic [be_pkg::CSR_ADDR_WD-1:0] o_ws_csr_rd,
  // read ports
  input  logic [be_pkg::GPR_ADDR_WD-1:0] i_gpr_raddr,
  output logic [be_pkg::XLEN-1:0]        o_gpr_rdata,
  input  logic [be_pkg::CSR_ADDR_WD-1:0] i_csr_raddr,
  output logic [be_pkg::XLEN-1:0]        o_csr_rdata
);

  import be_pkg::*;

  logic            ms_to_ws_valid;
  ms_to_ws_t       ms_to_ws_bus;
  logic            ws_allowin;
  wb_req_t         wb_req;
  logic            wb_ack;
  logic [XLEN-1:0] wb_dat_r;
  ws_to_rf_t       ws_to_rf;

  mem_stage u_mem_stage (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_ex_valid       (i_ex_valid),
    .i_ex_bus         (i_ex_bus),
    .o_ms_allowin     (o_ms_allowin),
    .o_ms_to_ws_valid (ms_to_ws_valid),
    .o_ms_to_ws_bus   (ms_to_ws_bus),
    .i_ws_allowin     (ws_allowin),
    .o_wb_req         (wb_req),
    .i_wb_ack         (wb_ack),
    .i_wb_dat_r       (wb_dat_r),
    .o_ms_gpr_rd      (o_ms_gpr_rd)
  );

  wb_stage u_wb_stage (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_ms_to_ws_valid (ms_to_ws_valid),
    .i_ms_to_ws_bus   (ms_to_ws_bus),
    .o_ws_allowin     (ws_allowin),
    .o_ws_to_rf       (ws_to_rf),
    .o_commit         (o_commit),
    .o_ws_gpr_rd      (o_ws_gpr_rd),
    .o_ws_csr_rd      (o_ws_csr_rd)
  );

  gpr_file u_gpr_file (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_wr    (ws_to_rf),
    .i_raddr (i_gpr_raddr),
    .o_rdata (o_gpr_rdata)
  );

  csr_file u_csr_file (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_wr    (ws_to_rf),
    .i_raddr (i_csr_raddr),
    .o_rdata (o_csr_rdata)
  );

  data_ram #(
    .RAM_AW (RAM_AW)
  ) u_data_ram (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_wb_req   (wb_req),
    .o_wb_ack   (wb_ack),
    .o_wb_dat_r (wb_dat_r)
  );

endmodule

//--- src/csr_file.sv
// machine CSR file: mstatus, mtvec, mepc and mcause

module csr_file (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  be_pkg::ws_to_rf_t              i_wr,
  input  logic [be_pkg::CSR_ADDR_WD-1:0] i_raddr,
  output logic [be_pkg::XLEN-1:0]        o_rdata
);

  import be_pkg::*;

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (i_wr.csr_wen) begin
      case (i_wr.csr_waddr)
        CSR_MSTATUS: mstatus <= i_wr.csr_wdata;
        CSR_MTVEC:   mtvec   <= i_wr.csr_wdata;
        CSR_MEPC:    mepc    <= i_wr.csr_wdata;
        CSR_MCAUSE:  mcause  <= i_wr.csr_wdata;
        // other addresses dropped
        default: ;
      endcase
    end
  end

  always_comb begin
    case (i_raddr)
      CSR_MSTATUS: o_rdata = mstatus;
      CSR_MTVEC:   o_rdata = mtvec;
      CSR_MEPC:    o_rdata = mepc;
      CSR_MCAUSE:  o_rdata = mcause;
      default:     o_rdata = '0;
    endcase
  end

endmodule

//--- src/data_ram.sv
// word RAM behind a Wishbone classic slave port, ack one cycle after stb

module data_ram #(
  parameter int RAM_AW = 8
) (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  be_pkg::wb_req_t         i_wb_req,
  output logic                    o_wb_ack,
  output logic [be_pkg::XLEN-1:0] o_wb_dat_r
);

  import be_pkg::*;

  logic [XLEN-1:0]   mem [0:(1<<RAM_AW)-1];
  logic [RAM_AW-1:0] word_idx;
  logic              first_stb;

  // byte address, drop the low two bits
  assign word_idx  = i_wb_req.adr[RAM_AW+1:2];
  assign first_stb = i_wb_req.cyc && i_wb_req.stb && !o_wb_ack;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_ack <= 1'b0;
    end else begin
      o_wb_ack <= first_stb;
    end
  end

  always_ff @(posedge i_clk) begin
    if (first_stb) begin
      if (i_wb_req.we) begin
        mem[word_idx] <= i_wb_req.dat_w;
      end
      o_wb_dat_r <= mem[word_idx];
    end
  end

  // ack answers a cycle opened on the previous edge
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_wb_ack |-> $past(i_wb_req.cyc));

endmodule

//--- src/gpr_file.sv
// general register file, 31 storage words plus hard-wired x0

module gpr_file (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  input  be_pkg::ws_to_rf_t              i_wr,
  input  logic [be_pkg::GPR_ADDR_WD-1:0] i_raddr,
  output logic [be_pkg::XLEN-1:0]        o_rdata
);

  import be_pkg::*;

  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.gpr_wen && (i_wr.gpr_waddr != '0)) begin
      regs[i_wr.gpr_waddr] <= i_wr.gpr_wdata;
    end
  end

  // x0 reads zero
  assign o_rdata = (i_raddr == '0) ? '0 : regs[i_raddr];

endmodule

//--- src/mem_stage.sv
// memory stage: holds one item, runs a Wishbone word access for loads and stores

module mem_stage (
  input  logic                          i_clk,
  input  logic                          i_rst_n,
  // from execute
  input  logic                          i_ex_valid,
  input  be_pkg::ex_to_ms_t             i_ex_bus,
  output logic                          o_ms_allowin,
  // to write-back
  output logic                          o_ms_to_ws_valid,
  output be_pkg::ms_to_ws_t             o_ms_to_ws_bus,
  input  logic                          i_ws_allowin,
  // wishbone master
  output be_pkg::wb_req_t               o_wb_req,
  input  logic                          i_wb_ack,
  input  logic [be_pkg::XLEN-1:0]       i_wb_dat_r,
  // hazard destination
  output logic [be_pkg::GPR_ADDR_WD-1:0] o_ms_gpr_rd
);

  import be_pkg::*;

  logic            ms_valid;
  ex_to_ms_t       ms_bus;
  logic            ms_ready_go;
  logic            ms_is_mem;
  logic            ms_acc_done;
  logic [XLEN-1:0] ms_rdata_r;
  logic [XLEN-1:0] ms_ld_data;

  assign ms_is_mem    = (ms_bus.mem_op != MEM_NONE);
  // ack marks the access finished, the done flag covers a stalled hand-off
  assign ms_ready_go  = !ms_is_mem || i_wb_ack || ms_acc_done;
  assign o_ms_allowin = !ms_valid || (ms_ready_go && i_ws_allowin);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ms_valid <= 1'b0;
    end else if (o_ms_allowin) begin
      ms_valid <= i_ex_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ex_valid && o_ms_allowin) begin
      ms_bus <= i_ex_bus;
    end
  end

  // ack seen while write-back refused the item
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ms_acc_done <= 1'b0;
    end else if (o_ms_allowin) begin
      ms_acc_done <= 1'b0;
    end else if (i_wb_ack) begin
      ms_acc_done <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wb_ack) begin
      ms_rdata_r <= i_wb_dat_r;
    end
  end

  always_comb begin
    o_wb_req.cyc   = ms_valid && ms_is_mem && !ms_acc_done;
    o_wb_req.stb   = o_wb_req.cyc;
    o_wb_req.we    = (ms_bus.mem_op == MEM_SW);
    o_wb_req.adr   = ms_bus.alu_result;
    o_wb_req.dat_w = ms_bus.store_data;
  end

  assign ms_ld_data = ms_acc_done ? ms_rdata_r : i_wb_dat_r;

  assign o_ms_to_ws_valid = ms_valid && ms_ready_go;

  always_comb begin
    o_ms_to_ws_bus.pc         = ms_bus.pc;
    o_ms_to_ws_bus.inst       = ms_bus.inst;
    o_ms_to_ws_bus.gpr_wen    = ms_bus.gpr_wen;
    o_ms_to_ws_bus.rd         = ms_bus.rd;
    o_ms_to_ws_bus.gpr_result = (ms_bus.mem_op == MEM_LW) ? ms_ld_data : ms_bus.alu_result;
    o_ms_to_ws_bus.csr_wen    = ms_bus.csr_wen;
    o_ms_to_ws_bus.csr        = ms_bus.csr;
    o_ms_to_ws_bus.csr_result = ms_bus.csr_wdata;
  end

  assign o_ms_gpr_rd = (ms_valid && ms_bus.gpr_wen) ? ms_bus.rd : '0;

  // strobe only inside a bus cycle
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(o_wb_req.stb) |-> o_wb_req.cyc);

  // request held steady until the slave answers
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_wb_req.cyc && !i_wb_ack) |=> (o_wb_req.cyc && $stable(o_wb_req.adr)));

endmodule

//--- src/wb_stage.sv
// write-back stage: commits one item per cycle to the register files

module wb_stage (
  input  logic                           i_clk,
  input  logic                           i_rst_n,
  // from memory stage
  input  logic                           i_ms_to_ws_valid,
  input  be_pkg::ms_to_ws_t              i_ms_to_ws_bus,
  output logic                           o_ws_allowin,
  // register write bus
  output be_pkg::ws_to_rf_t              o_ws_to_rf,
  // debug commit
  output be_pkg::commit_t                o_commit,
  // hazard destinations
  output logic [be_pkg::GPR_ADDR_WD-1:0] o_ws_gpr_rd,
  output logic [be_pkg::CSR_ADDR_WD-1:0] o_ws_csr_rd
);

  import be_pkg::*;

  logic      ws_valid;
  logic      ws_ready_go;
  ms_to_ws_t ws_bus;
  logic      ws_gpr_wen;
  logic      ws_csr_wen;

  // last stage, never stalls
  assign ws_ready_go  = 1'b1;
  assign o_ws_allowin = !ws_valid || ws_ready_go;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ws_valid <= 1'b0;
    end else if (o_ws_allowin) begin
      ws_valid <= i_ms_to_ws_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ms_to_ws_valid && o_ws_allowin) begin
      ws_bus <= i_ms_to_ws_bus;
    end
  end

  assign ws_gpr_wen = ws_valid && ws_bus.gpr_wen;
  assign ws_csr_wen = ws_valid && ws_bus.csr_wen;

  always_comb begin
    o_ws_to_rf.gpr_wen   = ws_gpr_wen;
    o_ws_to_rf.gpr_waddr = ws_bus.rd;
    o_ws_to_rf.gpr_wdata = ws_bus.gpr_result;
    o_ws_to_rf.csr_wen   = ws_csr_wen;
    o_ws_to_rf.csr_waddr = ws_bus.csr;
    o_ws_to_rf.csr_wdata = ws_bus.csr_result;
  end

  always_comb begin
    o_commit.valid    = ws_valid;
    o_commit.pc       = ws_bus.pc;
    o_commit.inst     = ws_bus.inst;
    o_commit.gpr_wen  = ws_gpr_wen;
    o_commit.rd       = ws_bus.rd;
    o_commit.gpr_data = ws_bus.gpr_result;
  end

  assign o_ws_gpr_rd = ws_gpr_wen ? ws_bus.rd : '0;
  assign o_ws_csr_rd = ws_csr_wen ? ws_bus.csr : '0;

  assert property (@(posedge i_clk) disable iff (!i_rst_n) !$isunknown(ws_valid));

endmodule

//--- tests/be_tb.sv
// testbench for the pipeline back end with a random item stream, reference model and commit checks

module be_tb;

  import be_pkg::*;

  localparam int RAM_AW         = 8;
  localparam int N_ITEMS        = 400;
  localparam int SEED           = 57;
  localparam int RAM_WORDS_USED = 16;
  localparam int TIMEOUT_CYCLES = 16 + N_ITEMS * 3 + 200;
  localparam logic [CSR_ADDR_WD-1:0] CSR_UNIMPL_A = 12'h340;
  localparam logic [CSR_ADDR_WD-1:0] CSR_UNIMPL_B = 12'h7c0;

  logic                   clk;
  logic                   rst_n;
  logic                   ex_valid;
  ex_to_ms_t              ex_bus;
  logic                   ms_allowin;
  commit_t                commit;
  logic [GPR_ADDR_WD-1:0] ms_gpr_rd;
  logic [GPR_ADDR_WD-1:0] ws_gpr_rd;
  logic [CSR_ADDR_WD-1:0] ws_csr_rd;
  logic [GPR_ADDR_WD-1:0] gpr_raddr;
  logic [XLEN-1:0]        gpr_rdata;
  logic [CSR_ADDR_WD-1:0] csr_raddr;
  logic [XLEN-1:0]        csr_rdata;

  // reference state
  logic [XLEN-1:0]        gpr_model [0:31];
  logic [XLEN-1:0]        csr_model [0:3];
  logic [XLEN-1:0]        ram_model [0:(1<<RAM_AW)-1];
  logic                   ram_written [0:(1<<RAM_AW)-1];
  int                     last_store;
  commit_t                exp_q [$];
  logic [CSR_ADDR_WD-1:0] exp_csr_q [$];
  logic [GPR_ADDR_WD-1:0] ms_rd_exp;
  int                     ms_hold;
  int                     commit_count;
  int                     cycle_count;

  be_top #(
    .RAM_AW (RAM_AW)
  ) dut0 (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_ex_valid  (ex_valid),
    .i_ex_bus    (ex_bus),
    .o_ms_allowin(ms_allowin),
    .o_commit    (commit),
    .o_ms_gpr_rd (ms_gpr_rd),
    .o_ws_gpr_rd (ws_gpr_rd),
    .o_ws_csr_rd (ws_csr_rd),
    .i_gpr_raddr (gpr_raddr),
    .o_gpr_rdata (gpr_rdata),
    .i_csr_raddr (csr_raddr),
    .o_csr_rdata (csr_rdata)
  );

  always #50 clk = ~clk;

  task automatic end_with_failure();
    $display("=== FAIL ===");
    $fatal(1, "stopping at first error");
  endtask

  function automatic string commit_str(input commit_t c);
    return $sformatf("{v=%0b pc=%h inst=%h wen=%0b rd=%0d data=%h}",
                     c.valid, c.pc, c.inst, c.gpr_wen, c.rd, c.gpr_data);
  endfunction

  task automatic check_commit(input commit_t got, input commit_t exp);
    if (got !== exp) begin
      $display("FAIL t=%0t o_commit got %s expected %s",
               $time, commit_str(got), commit_str(exp));
      end_with_failure();
    end
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_gpr_idx(input string name, input logic [GPR_ADDR_WD-1:0] got,
                               input logic [GPR_ADDR_WD-1:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_csr_idx(input string name, input logic [CSR_ADDR_WD-1:0] got,
                               input logic [CSR_ADDR_WD-1:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  // -1 for addresses outside the four machine CSRs
  function automatic int csr_slot(input logic [CSR_ADDR_WD-1:0] addr);
    case (addr)
      CSR_MSTATUS: return 0;
      CSR_MTVEC:   return 1;
      CSR_MEPC:    return 2;
      CSR_MCAUSE:  return 3;
      default:     return -1;
    endcase
  endfunction

  function automatic logic [CSR_ADDR_WD-1:0] pick_csr();
    case ($urandom % 6)
      0:       return CSR_MSTATUS;
      1:       return CSR_MTVEC;
      2:       return CSR_MEPC;
      3:       return CSR_MCAUSE;
      4:       return CSR_UNIMPL_A;
      default: return CSR_UNIMPL_B;
    endcase
  endfunction

  // kind 0 is an alu write, 1 a load, 2 a store and 3 a csr write
  function automatic ex_to_ms_t make_item(input int n);
    ex_to_ms_t   it;
    int unsigned kind;
    int unsigned idx;
    it = '0;
    it.pc = XLEN'(32'h0000_1000 + n * 4);
    it.inst = $urandom;
    it.mem_op = MEM_NONE;
    kind = $urandom % 4;
    idx = $urandom % RAM_WORDS_USED;
    // loads only from words already stored
    if (kind == 1 && !ram_written[idx]) begin
      if (last_store < 0) begin
        kind = 2;
      end else begin
        idx = last_store;
      end
    end
    it.rd = (($urandom % 8) == 0) ? '0 : GPR_ADDR_WD'($urandom % 32);
    case (kind)
      0: begin
        it.gpr_wen = 1'b1;
        it.alu_result = $urandom;
      end
      1: begin
        it.mem_op = MEM_LW;
        it.gpr_wen = 1'b1;
        it.alu_result = XLEN'(idx << 2);
      end
      2: begin
        it.mem_op = MEM_SW;
        it.alu_result = XLEN'(idx << 2);
        it.store_data = $urandom;
      end
      default: begin
        it.alu_result = $urandom;
        it.csr_wen = 1'b1;
        it.csr = pick_csr();
        it.csr_wdata = $urandom;
      end
    endcase
    return it;
  endfunction

  // applies an accepted item to the model and queues its commit
  function automatic void apply_item(input ex_to_ms_t it);
    commit_t         c;
    int              slot;
    int              widx;
    logic [XLEN-1:0] result;
    widx = int'(it.alu_result[RAM_AW+1:2]);
    result = (it.mem_op == MEM_LW) ? ram_model[widx] : it.alu_result;
    if (it.mem_op == MEM_SW) begin
      ram_model[widx] = it.store_data;
      ram_written[widx] = 1'b1;
      last_store = widx;
    end
    if (it.gpr_wen && it.rd != '0) begin
      gpr_model[it.rd] = result;
    end
    if (it.csr_wen) begin
      slot = csr_slot(it.csr);
      if (slot >= 0) begin
        csr_model[slot] = it.csr_wdata;
      end
    end
    c.valid = 1'b1;
    c.pc = it.pc;
    c.inst = it.inst;
    c.gpr_wen = it.gpr_wen;
    c.rd = it.rd;
    c.gpr_data = result;
    exp_q.push_back(c);
    exp_csr_q.push_back(it.csr_wen ? it.csr : '0);
  endfunction

  // enters at posedge+5 and returns at posedge+5 after the accepting edge
  task automatic send_item(input ex_to_ms_t it);
    ex_valid = 1'b1;
    ex_bus = it;
    @(negedge clk);
    while (!ms_allowin) begin
      @(negedge clk);
    end
    apply_item(it);
    @(posedge clk);
    // memory stage holds the item one cycle, two for a bus access
    ms_rd_exp = it.gpr_wen ? it.rd : '0;
    ms_hold = (it.mem_op == MEM_NONE) ? 1 : 2;
    #5;
  endtask

  task automatic readback_csr(input logic [CSR_ADDR_WD-1:0] addr);
    logic [XLEN-1:0] exp;
    int              slot;
    slot = csr_slot(addr);
    exp = (slot < 0) ? '0 : csr_model[slot];
    csr_raddr = addr;
    @(negedge clk);
    check_word($sformatf("o_csr_rdata[%h]", addr), csr_rdata, exp);
    @(posedge clk);
    #5;
  endtask

  // commit compare sampled mid-cycle
  always @(negedge clk) begin
    commit_t                exp;
    logic [CSR_ADDR_WD-1:0] exp_csr;
    if (rst_n) begin
      if (commit.valid) begin
        if (exp_q.size() == 0) begin
          $display("commit of pc %h arrived with no item outstanding", commit.pc);
          end_with_failure();
        end else begin
          exp = exp_q.pop_front();
          exp_csr = exp_csr_q.pop_front();
          check_commit(commit, exp);
          check_gpr_idx("o_ws_gpr_rd", ws_gpr_rd, exp.gpr_wen ? exp.rd : '0);
          check_csr_idx("o_ws_csr_rd", ws_csr_rd, exp_csr);
          commit_count++;
        end
      end else begin
        check_gpr_idx("o_ws_gpr_rd", ws_gpr_rd, '0);
        check_csr_idx("o_ws_csr_rd", ws_csr_rd, '0);
      end
      if (ms_hold > 0) begin
        check_gpr_idx("o_ms_gpr_rd", ms_gpr_rd, ms_rd_exp);
        ms_hold--;
      end else begin
        check_gpr_idx("o_ms_gpr_rd", ms_gpr_rd, '0);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d items committed",
               cycle_count, commit_count, N_ITEMS);
      end_with_failure();
    end
  end

  initial begin
    int n;
    int i;
    void'($urandom(SEED));
    clk = 1'b0;
    rst_n = 1'b0;
    ex_valid = 1'b0;
    ex_bus = '0;
    gpr_raddr = '0;
    csr_raddr = '0;
    last_store = -1;
    ms_rd_exp = '0;
    ms_hold = 0;
    commit_count = 0;
    cycle_count = 0;
    for (i = 0; i < 32; i++) begin
      gpr_model[i] = '0;
    end
    for (i = 0; i < 4; i++) begin
      csr_model[i] = '0;
    end
    for (i = 0; i < (1 << RAM_AW); i++) begin
      ram_written[i] = 1'b0;
    end
    repeat (16) @(posedge clk);
    #5;
    rst_n = 1'b1;
    @(negedge clk);
    if (!ms_allowin) begin
      $display("memory stage does not accept items after reset");
      end_with_failure();
    end
    @(posedge clk);
    #5;
    for (n = 0; n < N_ITEMS; n++) begin
      // occasional bubble
      if (($urandom % 8) == 0) begin
        ex_valid = 1'b0;
        @(posedge clk);
        #5;
      end
      send_item(make_item(n));
    end
    ex_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    @(posedge clk);
    #5;
    for (i = 0; i < 32; i++) begin
      gpr_raddr = GPR_ADDR_WD'(i);
      @(negedge clk);
      check_word($sformatf("o_gpr_rdata[x%0d]", i), gpr_rdata, gpr_model[i]);
      @(posedge clk);
      #5;
    end
    readback_csr(CSR_MSTATUS);
    readback_csr(CSR_MTVEC);
    readback_csr(CSR_MEPC);
    readback_csr(CSR_MCAUSE);
    readback_csr(CSR_UNIMPL_A);
    if (commit_count == N_ITEMS) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("%0d of %0d items committed", commit_count, N_ITEMS);
      end_with_failure();
    end
  end

endmodule
